// ==== common/axi_pkg.sv ====
package axi_pkg;

	parameter int ID_W   = 4;
	parameter int ADDR_W = 32;
	parameter int DATA_W = 64;
	parameter int LEN_W  = 8; // Beats minus one
	parameter int STRB_W = DATA_W / 8;

	typedef enum logic [1:0] {
		SIZE_B = 2'b00,
		SIZE_H = 2'b01,
		SIZE_W = 2'b10,
		SIZE_D = 2'b11
	} size_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_e;

	typedef enum logic [1:0] {
		BURST_FIXED = 2'b00,
		BURST_INCR  = 2'b01,
		BURST_WRAP  = 2'b10
	} burst_e;

	typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA, WR_RESP} wr_state_e;
	typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_e;
	typedef enum logic [1:0] {M_IDLE, M_WRITE, M_WRESP, M_READ} mem_state_e;

	// Address step of one beat
	function automatic logic [3:0] size_bytes(input size_e s);
		return 4'd1 << s;
	endfunction

endpackage

// ==== common/axi_if.sv ====
`timescale 1ns/10ps
interface axi_if #(
	parameter int ID_WIDTH   = axi_pkg::ID_W,
	parameter int ADDR_WIDTH = axi_pkg::ADDR_W
);
	import axi_pkg::*;

	logic awvalid;
	logic awready;
	logic [ID_WIDTH-1:0] awid;
	logic [ADDR_WIDTH-1:0] awaddr;
	logic [LEN_W-1:0] awlen;
	logic [2:0] awsize;
	burst_e awburst;

	logic wvalid;
	logic wready;
	logic [DATA_W-1:0] wdata;
	logic [STRB_W-1:0] wstrb;
	logic wlast;

	logic bvalid;
	logic bready;
	logic [ID_WIDTH-1:0] bid;
	resp_e bresp;

	logic arvalid;
	logic arready;
	logic [ID_WIDTH-1:0] arid;
	logic [ADDR_WIDTH-1:0] araddr;
	logic [LEN_W-1:0] arlen;
	logic [2:0] arsize;
	burst_e arburst;

	logic rvalid;
	logic rready;
	logic [ID_WIDTH-1:0] rid;
	logic [DATA_W-1:0] rdata;
	resp_e rresp;
	logic rlast;

	modport wr_mst (
		output awvalid, awid, awaddr, awlen, awsize, awburst,
		output wvalid, wdata, wstrb, wlast, bready,
		input awready, wready, bvalid, bid, bresp
	);

	modport rd_mst (
		output arvalid, arid, araddr, arlen, arsize, arburst, rready,
		input arready, rvalid, rid, rdata, rresp, rlast
	);

	modport slv (
		input awvalid, awid, awaddr, awlen, awsize, awburst,
		input wvalid, wdata, wstrb, wlast, bready,
		input arvalid, arid, araddr, arlen, arsize, arburst, rready,
		output awready, wready, bvalid, bid, bresp,
		output arready, rvalid, rid, rdata, rresp, rlast
	);

endinterface

// ==== axi_bridge/axi_write_master.sv ====
`timescale 1ns/10ps
module axi_write_master #(
	parameter int ID_WIDTH   = axi_pkg::ID_W,
	parameter int ADDR_WIDTH = axi_pkg::ADDR_W
) (
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic                       cpu_aw_valid_i,
	input  logic [ID_WIDTH-1:0]        cpu_w_id_i,
	input  logic [ADDR_WIDTH-1:0]      cpu_w_addr_i,
	input  logic [axi_pkg::LEN_W-1:0]  cpu_w_len_i,
	input  axi_pkg::size_e             cpu_w_size_i,
	input  logic [axi_pkg::DATA_W-1:0] cpu_w_data_i,
	output logic                       cpu_aw_ready_o,
	output logic                       cpu_w_next_o,
	output logic                       cpu_w_done_o,
	output axi_pkg::resp_e             cpu_w_resp_o,
	axi_if.wr_mst                      axi
);
	import axi_pkg::*;

	wr_state_e state;
	wr_state_e state_nxt;
	logic [ID_WIDTH-1:0] id_q;
	logic [ADDR_WIDTH-1:0] addr_q; // AW address, then beat address
	logic [LEN_W-1:0] len_q;
	logic [LEN_W-1:0] beat_cnt;
	size_e size_q;
	logic [STRB_W-1:0] size_mask;
	logic req_hs;
	logic aw_hs;
	logic w_hs;
	logic b_hs;

	assign req_hs = cpu_aw_valid_i && cpu_aw_ready_o;
	assign aw_hs  = axi.awvalid && axi.awready;
	assign w_hs   = axi.wvalid && axi.wready;
	assign b_hs   = axi.bvalid && axi.bready;

	assign cpu_aw_ready_o = state == WR_IDLE;
	assign cpu_w_next_o   = w_hs; // CPU moves to the next beat's data

	assign axi.awvalid = state == WR_ADDR;
	assign axi.awid    = id_q;
	assign axi.awaddr  = addr_q;
	assign axi.awlen   = len_q;
	assign axi.awsize  = {1'b0, size_q};
	assign axi.awburst = BURST_INCR;

	always_comb begin
		case (size_q)
			SIZE_B:  size_mask = 8'h01;
			SIZE_H:  size_mask = 8'h03;
			SIZE_W:  size_mask = 8'h0f;
			default: size_mask = 8'hff;
		endcase
	end

	assign axi.wvalid = state == WR_DATA;
	assign axi.wdata  = cpu_w_data_i;
	assign axi.wstrb  = size_mask << addr_q[2:0];
	assign axi.wlast  = beat_cnt == len_q;
	assign axi.bready = state == WR_RESP;

	always_comb begin
		state_nxt = state;
		case (state)
			WR_IDLE: if (cpu_aw_valid_i) state_nxt = WR_ADDR;
			WR_ADDR: if (aw_hs) state_nxt = WR_DATA;
			WR_DATA: if (w_hs && axi.wlast) state_nxt = WR_RESP;
			WR_RESP: if (b_hs) state_nxt = WR_IDLE;
			default: state_nxt = WR_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= WR_IDLE;
			beat_cnt <= '0;
			cpu_w_done_o <= 1'b0;
			cpu_w_resp_o <= RESP_OKAY;
		end else begin
			state <= state_nxt;
			cpu_w_done_o <= b_hs;
			if (req_hs)
				beat_cnt <= '0;
			else if (w_hs)
				beat_cnt <= beat_cnt + 1'b1;
			if (b_hs)
				cpu_w_resp_o <= axi.bresp;
		end
	end

	always_ff @(posedge clk) begin
		if (req_hs) begin
			id_q <= cpu_w_id_i;
			addr_q <= cpu_w_addr_i;
			len_q <= cpu_w_len_i;
			size_q <= cpu_w_size_i;
		end else if (w_hs) begin
			addr_q <= addr_q + ADDR_WIDTH'(size_bytes(size_q));
		end
	end

	a_aw_stable: assert property (@(posedge clk) disable iff (!reset_n)
		axi.awvalid && !axi.awready |=> axi.awvalid && $stable(axi.awaddr));

	// Beat count never runs past the burst length
	a_wlast_beat: assert property (@(posedge clk) disable iff (!reset_n)
		w_hs |-> beat_cnt <= len_q);

	// No W beat follows the last one
	a_w_after_last: assert property (@(posedge clk) disable iff (!reset_n)
		w_hs && axi.wlast |=> !axi.wvalid);

	a_bid_echo: assert property (@(posedge clk) disable iff (!reset_n)
		b_hs |-> axi.bid == id_q);

endmodule

// ==== axi_bridge/axi_read_master.sv ====
`timescale 1ns/10ps
module axi_read_master #(
	parameter int ID_WIDTH   = axi_pkg::ID_W,
	parameter int ADDR_WIDTH = axi_pkg::ADDR_W
) (
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic                       cpu_ar_valid_i,
	input  logic [ID_WIDTH-1:0]        cpu_r_id_i,
	input  logic [ADDR_WIDTH-1:0]      cpu_r_addr_i,
	input  logic [axi_pkg::LEN_W-1:0]  cpu_r_len_i,
	input  axi_pkg::size_e             cpu_r_size_i,
	output logic                       cpu_ar_ready_o,
	output logic                       cpu_r_valid_o,
	output logic [axi_pkg::DATA_W-1:0] cpu_r_data_o,
	output logic                       cpu_r_last_o,
	output axi_pkg::resp_e             cpu_r_resp_o,
	axi_if.rd_mst                      axi
);
	import axi_pkg::*;

	rd_state_e state;
	rd_state_e state_nxt;
	logic [ID_WIDTH-1:0] id_q;
	logic [ADDR_WIDTH-1:0] addr_q;
	logic [LEN_W-1:0] len_q;
	size_e size_q;
	logic req_hs;
	logic ar_hs;
	logic r_hs;

	assign req_hs = cpu_ar_valid_i && cpu_ar_ready_o;
	assign ar_hs  = axi.arvalid && axi.arready;
	assign r_hs   = axi.rvalid && axi.rready;

	assign cpu_ar_ready_o = state == RD_IDLE;

	assign axi.arvalid = state == RD_ADDR;
	assign axi.arid    = id_q;
	assign axi.araddr  = addr_q;
	assign axi.arlen   = len_q;
	assign axi.arsize  = {1'b0, size_q};
	assign axi.arburst = BURST_INCR;
	assign axi.rready  = state == RD_DATA; // Held through all beats

	always_comb begin
		state_nxt = state;
		case (state)
			RD_IDLE: if (cpu_ar_valid_i) state_nxt = RD_ADDR;
			RD_ADDR: if (ar_hs) state_nxt = RD_DATA;
			RD_DATA: if (r_hs && axi.rlast) state_nxt = RD_IDLE;
			default: state_nxt = RD_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= RD_IDLE;
			cpu_r_valid_o <= 1'b0;
		end else begin
			state <= state_nxt;
			cpu_r_valid_o <= r_hs;
		end
	end

	always_ff @(posedge clk) begin
		if (req_hs) begin
			id_q <= cpu_r_id_i;
			addr_q <= cpu_r_addr_i;
			len_q <= cpu_r_len_i;
			size_q <= cpu_r_size_i;
		end
		if (r_hs) begin
			cpu_r_data_o <= axi.rdata;
			cpu_r_last_o <= axi.rlast;
			cpu_r_resp_o <= axi.rresp;
		end
	end

	// Slave may only answer the AR this master issued
	a_r_in_data: assert property (@(posedge clk) disable iff (!reset_n)
		axi.rvalid |-> state == RD_DATA && axi.rid == id_q);

endmodule

// ==== design/axi_mem.sv ====
`timescale 1ns/10ps
module axi_mem #(
	parameter int ID_WIDTH   = axi_pkg::ID_W,
	parameter int ADDR_WIDTH = axi_pkg::ADDR_W,
	parameter int MEM_WORDS  = 256
) (
	input logic clk,
	input logic reset_n,
	axi_if.slv  axi
);
	import axi_pkg::*;

	localparam int IDX_W = $clog2(MEM_WORDS);

	logic [DATA_W-1:0] mem [MEM_WORDS];
	mem_state_e state;
	mem_state_e state_nxt;
	logic [ID_WIDTH-1:0] id_q;
	logic [ADDR_WIDTH-1:0] addr_q; // Current beat address
	logic [ADDR_WIDTH-1:0] addr_nxt;
	logic [ADDR_WIDTH-1:0] rd_addr;
	logic [LEN_W-1:0] len_q;
	logic [LEN_W-1:0] beat_cnt;
	size_e size_q;
	logic err_q;
	logic aw_hs, w_hs, b_hs, ar_hs, r_hs;
	logic [ADDR_WIDTH-1:0] req_addr;
	logic [LEN_W-1:0] req_len;
	logic [2:0] req_size;
	burst_e req_burst;
	logic [ADDR_WIDTH:0] req_end; // Byte address of the last beat
	logic req_err;
	logic rd_err;
	logic [DATA_W-1:0] rdata_q;

	assign axi.awready = state == M_IDLE;
	assign axi.arready = state == M_IDLE && !axi.awvalid; // AW wins a tie
	assign axi.wready  = state == M_WRITE;
	assign axi.bvalid  = state == M_WRESP;
	assign axi.rvalid  = state == M_READ;

	assign aw_hs = axi.awvalid && axi.awready;
	assign ar_hs = axi.arvalid && axi.arready;
	assign w_hs  = axi.wvalid && axi.wready;
	assign b_hs  = axi.bvalid && axi.bready;
	assign r_hs  = axi.rvalid && axi.rready;

	assign req_addr  = aw_hs ? axi.awaddr : axi.araddr;
	assign req_len   = aw_hs ? axi.awlen : axi.arlen;
	assign req_size  = aw_hs ? axi.awsize : axi.arsize;
	assign req_burst = aw_hs ? axi.awburst : axi.arburst;
	assign req_end   = {1'b0, req_addr} + ((ADDR_WIDTH+1)'(req_len) << req_size);

	// Out of range, wider than the bus, or not INCR
	assign req_err = (req_end[ADDR_WIDTH:3] >= MEM_WORDS) || req_size[2] ||
		(req_burst != BURST_INCR);

	assign addr_nxt = addr_q + ADDR_WIDTH'(size_bytes(size_q));
	assign rd_addr  = ar_hs ? axi.araddr : addr_nxt;
	assign rd_err   = ar_hs ? req_err : err_q;

	assign axi.bid   = id_q;
	assign axi.bresp = err_q ? RESP_SLVERR : RESP_OKAY;
	assign axi.rid   = id_q;
	assign axi.rdata = rdata_q;
	assign axi.rresp = err_q ? RESP_SLVERR : RESP_OKAY;
	assign axi.rlast = beat_cnt == len_q;

	always_comb begin
		state_nxt = state;
		case (state)
			M_IDLE:
				if (aw_hs)
					state_nxt = M_WRITE;
				else if (ar_hs)
					state_nxt = M_READ;
			M_WRITE: if (w_hs && axi.wlast) state_nxt = M_WRESP;
			M_WRESP: if (b_hs) state_nxt = M_IDLE;
			M_READ:  if (r_hs && axi.rlast) state_nxt = M_IDLE;
			default: state_nxt = M_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= M_IDLE;
			beat_cnt <= '0;
			err_q <= 1'b0;
		end else begin
			state <= state_nxt;
			if (aw_hs || ar_hs) begin
				beat_cnt <= '0;
				err_q <= req_err;
			end else if (r_hs) begin
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (aw_hs || ar_hs) begin
			id_q <= aw_hs ? axi.awid : axi.arid;
			addr_q <= req_addr;
			len_q <= req_len;
			size_q <= size_e'(req_size[1:0]);
		end else if (w_hs || r_hs) begin
			addr_q <= addr_nxt;
		end
	end

	// Prefetch for the first beat and after each accepted beat
	always_ff @(posedge clk) begin
		if (ar_hs || (r_hs && !axi.rlast))
			rdata_q <= rd_err ? '0 : mem[rd_addr[IDX_W+2:3]];
	end

	always_ff @(posedge clk) begin
		if (w_hs && !err_q) begin
			for (int b = 0; b < STRB_W; b++)
				if (axi.wstrb[b])
					mem[addr_q[IDX_W+2:3]][8*b +: 8] <= axi.wdata[8*b +: 8];
		end
	end

	a_wstrb_nonzero: assert property (@(posedge clk) disable iff (!reset_n)
		w_hs |-> axi.wstrb != '0);

endmodule

// ==== design/mem_port_top.sv ====
`timescale 1ns/10ps
module mem_port_top #(
	parameter int ID_WIDTH   = axi_pkg::ID_W,
	parameter int ADDR_WIDTH = axi_pkg::ADDR_W,
	parameter int MEM_WORDS  = 256
) (
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic                       cpu_aw_valid_i,
	output logic                       cpu_aw_ready_o,
	input  logic [ID_WIDTH-1:0]        cpu_w_id_i,
	input  logic [ADDR_WIDTH-1:0]      cpu_w_addr_i,
	input  logic [axi_pkg::LEN_W-1:0]  cpu_w_len_i,
	input  axi_pkg::size_e             cpu_w_size_i,
	input  logic [axi_pkg::DATA_W-1:0] cpu_w_data_i,
	output logic                       cpu_w_next_o,
	output logic                       cpu_w_done_o,
	output axi_pkg::resp_e             cpu_w_resp_o,
	input  logic                       cpu_ar_valid_i,
	output logic                       cpu_ar_ready_o,
	input  logic [ID_WIDTH-1:0]        cpu_r_id_i,
	input  logic [ADDR_WIDTH-1:0]      cpu_r_addr_i,
	input  logic [axi_pkg::LEN_W-1:0]  cpu_r_len_i,
	input  axi_pkg::size_e             cpu_r_size_i,
	output logic                       cpu_r_valid_o,
	output logic [axi_pkg::DATA_W-1:0] cpu_r_data_o,
	output logic                       cpu_r_last_o,
	output axi_pkg::resp_e             cpu_r_resp_o
);

	// Shared bus, write and read channels run independently
	axi_if #(.ID_WIDTH(ID_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) axi_bus ();

	axi_write_master #(.ID_WIDTH(ID_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) wr_mst_i (
		.clk            (clk),
		.reset_n        (reset_n),
		.cpu_aw_valid_i (cpu_aw_valid_i),
		.cpu_w_id_i     (cpu_w_id_i),
		.cpu_w_addr_i   (cpu_w_addr_i),
		.cpu_w_len_i    (cpu_w_len_i),
		.cpu_w_size_i   (cpu_w_size_i),
		.cpu_w_data_i   (cpu_w_data_i),
		.cpu_aw_ready_o (cpu_aw_ready_o),
		.cpu_w_next_o   (cpu_w_next_o),
		.cpu_w_done_o   (cpu_w_done_o),
		.cpu_w_resp_o   (cpu_w_resp_o),
		.axi            (axi_bus.wr_mst)
	);

	axi_read_master #(.ID_WIDTH(ID_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) rd_mst_i (
		.clk            (clk),
		.reset_n        (reset_n),
		.cpu_ar_valid_i (cpu_ar_valid_i),
		.cpu_r_id_i     (cpu_r_id_i),
		.cpu_r_addr_i   (cpu_r_addr_i),
		.cpu_r_len_i    (cpu_r_len_i),
		.cpu_r_size_i   (cpu_r_size_i),
		.cpu_ar_ready_o (cpu_ar_ready_o),
		.cpu_r_valid_o  (cpu_r_valid_o),
		.cpu_r_data_o   (cpu_r_data_o),
		.cpu_r_last_o   (cpu_r_last_o),
		.cpu_r_resp_o   (cpu_r_resp_o),
		.axi            (axi_bus.rd_mst)
	);

	axi_mem #(
		.ID_WIDTH   (ID_WIDTH),
		.ADDR_WIDTH (ADDR_WIDTH),
		.MEM_WORDS  (MEM_WORDS)
	) mem_i (
		.clk     (clk),
		.reset_n (reset_n),
		.axi     (axi_bus.slv)
	);

endmodule

// ==== verification/tb_mem_port.sv ====
`timescale 1ns/10ps
module tb_mem_port;
	import axi_pkg::*;

	localparam int MEM_WORDS      = 256;
	localparam int MEM_BYTES      = MEM_WORDS * 8;
	localparam int TIMEOUT_CYCLES = 40 * 40 + 200; // 40 bursts of up to 40 cycles

	logic clk = 1'b0;
	logic reset_n;
	logic cpu_aw_valid_i;
	logic cpu_aw_ready_o;
	logic [ID_W-1:0] cpu_w_id_i;
	logic [ADDR_W-1:0] cpu_w_addr_i;
	logic [LEN_W-1:0] cpu_w_len_i;
	size_e cpu_w_size_i;
	logic [DATA_W-1:0] cpu_w_data_i;
	logic cpu_w_next_o;
	logic cpu_w_done_o;
	resp_e cpu_w_resp_o;
	logic cpu_ar_valid_i;
	logic cpu_ar_ready_o;
	logic [ID_W-1:0] cpu_r_id_i;
	logic [ADDR_W-1:0] cpu_r_addr_i;
	logic [LEN_W-1:0] cpu_r_len_i;
	size_e cpu_r_size_i;
	logic cpu_r_valid_o;
	logic [DATA_W-1:0] cpu_r_data_o;
	logic cpu_r_last_o;
	resp_e cpu_r_resp_o;

	int errors = 0;
	int bursts = 0;
	int cycle_cnt = 0;
	int rst_cnt = 0;
	logic [31:0] rng_state = 32'd6486;

	logic [7:0] shadow [MEM_BYTES]; // Byte image of what the memory should hold
	bit known [MEM_BYTES];

	logic [ID_W-1:0] wr_id;
	logic [31:0] wr_addr;
	logic [7:0] wr_len;
	size_e wr_size;
	resp_e wr_resp;
	int wr_beats;
	logic [63:0] wr_data [8];

	logic [ID_W-1:0] rd_id;
	logic [31:0] rd_addr;
	logic [7:0] rd_len;
	size_e rd_size;
	resp_e rd_resp;
	logic [63:0] exp_data [8];
	logic [63:0] exp_mask [8]; // Lanes worth comparing on each beat
	logic [63:0] cur_exp_data;
	logic [63:0] cur_exp_mask;

	int w_next_cnt = 0;
	bit w_open = 1'b0;
	int r_beat = 0;
	bit r_open = 1'b0;

	mem_port_top #(.MEM_WORDS(MEM_WORDS)) dut_i (.*);

	always #5 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Byte lanes of one beat
	function automatic logic [7:0] lane_mask(input logic [31:0] addr, input size_e size);
		logic [15:0] ones;
		ones = (16'd1 << (16'd1 << size)) - 16'd1;
		return ones[7:0] << addr[2:0];
	endfunction

	task automatic flag_error(input string msg);
		errors++;
		$display("CHECK FAILED at %0t: %s", $time, msg);
	endtask

	task automatic prepare_write(input logic [31:0] addr, input logic [7:0] len, input size_e size);
		logic [31:0] hi;
		logic [31:0] lo;
		logic [31:0] baddr;
		logic [7:0] lanes;
		int i;
		int b;
		hi = next_rand();
		wr_id = hi[3:0];
		wr_addr = addr;
		wr_len = len;
		wr_size = size;
		wr_beats = int'(len) + 1;
		baddr = addr + (32'(len) << size);
		wr_resp = (int'(baddr >> 3) >= MEM_WORDS) ? RESP_SLVERR : RESP_OKAY;
		for (i = 0; i < wr_beats; i++) begin
			hi = next_rand();
			lo = next_rand();
			wr_data[i] = {hi, lo};
			baddr = addr + (32'(i) << size);
			lanes = lane_mask(baddr, size);
			for (b = 0; b < 8; b++)
				if (lanes[b] && wr_resp == RESP_OKAY) begin
					shadow[int'(baddr >> 3) * 8 + b] = wr_data[i][8*b +: 8];
					known[int'(baddr >> 3) * 8 + b] = 1'b1;
				end
		end
	endtask

	task automatic prepare_read(input logic [31:0] addr, input logic [7:0] len, input size_e size);
		logic [31:0] r;
		logic [31:0] baddr;
		logic [7:0] lanes;
		int i;
		int b;
		r = next_rand();
		rd_id = r[3:0];
		rd_addr = addr;
		rd_len = len;
		rd_size = size;
		baddr = addr + (32'(len) << size);
		rd_resp = (int'(baddr >> 3) >= MEM_WORDS) ? RESP_SLVERR : RESP_OKAY;
		for (i = 0; i <= int'(len); i++) begin
			baddr = addr + (32'(i) << size);
			lanes = lane_mask(baddr, size);
			exp_data[i] = '0;
			exp_mask[i] = (rd_resp == RESP_SLVERR) ? '1 : '0; // Error reads give zeros
			for (b = 0; b < 8; b++)
				if (rd_resp == RESP_OKAY && lanes[b] && known[int'(baddr >> 3) * 8 + b]) begin
					exp_data[i][8*b +: 8] = shadow[int'(baddr >> 3) * 8 + b];
					exp_mask[i][8*b +: 8] = 8'hff;
				end
		end
	endtask

	task automatic run_write();
		int idx;
		idx = 0;
		cpu_aw_valid_i <= 1'b1;
		cpu_w_id_i <= wr_id;
		cpu_w_addr_i <= wr_addr;
		cpu_w_len_i <= wr_len;
		cpu_w_size_i <= wr_size;
		cpu_w_data_i <= wr_data[0];
		do @(posedge clk); while (!cpu_aw_ready_o);
		cpu_aw_valid_i <= 1'b0;
		do begin
			@(posedge clk);
			if (cpu_w_next_o && idx < 7) begin
				idx++;
				cpu_w_data_i <= wr_data[idx];
			end
		end while (!cpu_w_done_o);
		bursts++;
	endtask

	task automatic run_read();
		cpu_ar_valid_i <= 1'b1;
		cpu_r_id_i <= rd_id;
		cpu_r_addr_i <= rd_addr;
		cpu_r_len_i <= rd_len;
		cpu_r_size_i <= rd_size;
		do @(posedge clk); while (!cpu_ar_ready_o);
		cpu_ar_valid_i <= 1'b0;
		do @(posedge clk); while (!(cpu_r_valid_o && cpu_r_last_o));
		bursts++;
	endtask

	// Burst bookkeeping seen by the assertions
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (!reset_n)
			rst_cnt <= rst_cnt + 1;
		if (cpu_aw_valid_i && cpu_aw_ready_o) begin
			w_next_cnt <= 0;
			w_open <= 1'b1;
		end else begin
			if (cpu_w_next_o)
				w_next_cnt <= w_next_cnt + 1;
			if (cpu_w_done_o)
				w_open <= 1'b0;
		end
		if (cpu_ar_valid_i && cpu_ar_ready_o) begin
			r_beat <= 0;
			r_open <= 1'b1;
		end else if (cpu_r_valid_o) begin
			r_beat <= r_beat + 1;
			if (cpu_r_last_o)
				r_open <= 1'b0;
		end
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Run timed out after %0d cycles without finishing", cycle_cnt);
			$display("Test failed");
			$finish;
		end
	end

	assign cur_exp_data = exp_data[r_beat[2:0]];
	assign cur_exp_mask = exp_mask[r_beat[2:0]];

	a_reset_values: assert property (@(posedge clk) (!reset_n && rst_cnt > 0) |->
		cpu_aw_ready_o && cpu_ar_ready_o && !cpu_w_done_o && !cpu_r_valid_o && !cpu_w_next_o)
		else flag_error("outputs not at reset values");

	a_w_next: assert property (@(posedge clk) disable iff (!reset_n)
		cpu_w_next_o |-> w_open && w_next_cnt < wr_beats)
		else flag_error("extra W beat pulse");

	a_w_done: assert property (@(posedge clk) disable iff (!reset_n)
		cpu_w_done_o |-> w_open && w_next_cnt == wr_beats)
		else flag_error("done pulse with wrong beat count");

	a_w_resp: assert property (@(posedge clk) disable iff (!reset_n)
		cpu_w_done_o |-> cpu_w_resp_o == wr_resp)
		else flag_error("write response differs");

	// Write port takes a new request in the cycle of the done pulse
	a_aw_ready: assert property (@(posedge clk) disable iff (!reset_n)
		cpu_w_done_o |-> cpu_aw_ready_o)
		else flag_error("write port not ready at done pulse");

	a_b_id: assert property (@(posedge clk) disable iff (!reset_n)
		dut_i.axi_bus.bvalid && dut_i.axi_bus.bready |-> dut_i.axi_bus.bid == wr_id)
		else flag_error("B ID differs from request ID");

	a_r_data: assert property (@(posedge clk) disable iff (!reset_n)
		cpu_r_valid_o |-> r_open && (((cpu_r_data_o ^ cur_exp_data) & cur_exp_mask) == 64'd0))
		else flag_error("read data differs from shadow memory");

	a_r_last: assert property (@(posedge clk) disable iff (!reset_n)
		cpu_r_valid_o |-> cpu_r_last_o == (r_beat == int'(rd_len)))
		else flag_error("read last flag on wrong beat");

	a_r_resp: assert property (@(posedge clk) disable iff (!reset_n)
		cpu_r_valid_o |-> cpu_r_resp_o == rd_resp)
		else flag_error("read response differs");

	a_r_id: assert property (@(posedge clk) disable iff (!reset_n)
		dut_i.axi_bus.rvalid && dut_i.axi_bus.rready |-> dut_i.axi_bus.rid == rd_id)
		else flag_error("R ID differs from request ID");

	// Read port takes a new request right after its last beat
	a_ar_ready: assert property (@(posedge clk) disable iff (!reset_n)
		cpu_r_valid_o && cpu_r_last_o |-> cpu_ar_ready_o)
		else flag_error("read port not ready after last beat");

	initial begin
		logic [31:0] r;
		logic [31:0] addr;
		logic [7:0] len;
		size_e size;
		int n;
		reset_n = 1'b0;
		cpu_aw_valid_i = 1'b0;
		cpu_w_id_i = '0;
		cpu_w_addr_i = '0;
		cpu_w_len_i = '0;
		cpu_w_size_i = SIZE_B;
		cpu_w_data_i = '0;
		cpu_ar_valid_i = 1'b0;
		cpu_r_id_i = '0;
		cpu_r_addr_i = '0;
		cpu_r_len_i = '0;
		cpu_r_size_i = SIZE_B;
		repeat (8) @(posedge clk);
		reset_n <= 1'b1;
		@(posedge clk);

		// Random bursts, each read back
		for (n = 0; n < 12; n++) begin
			r = next_rand();
			size = size_e'(r[1:0]);
			r = next_rand();
			len = 8'(r[2:0]);
			r = next_rand();
			addr = (r % (MEM_BYTES - 64)) & ~((32'd1 << size) - 32'd1);
			@(posedge clk);
			prepare_write(addr, len, size);
			run_write();
			@(posedge clk);
			prepare_read(addr, len, size);
			run_read();
		end

		// Narrow writes inside one doubleword
		@(posedge clk);
		prepare_write(32'h100, 8'd0, SIZE_D);
		run_write();
		@(posedge clk);
		prepare_write(32'h101, 8'd1, SIZE_B);
		run_write();
		@(posedge clk);
		prepare_write(32'h106, 8'd0, SIZE_H);
		run_write();
		@(posedge clk);
		prepare_read(32'h100, 8'd0, SIZE_D);
		run_read();

		// Bursts that run past the end of memory
		addr = MEM_BYTES - 16;
		@(posedge clk);
		prepare_write(addr, 8'd1, SIZE_D);
		run_write();
		@(posedge clk);
		prepare_write(addr, 8'd3, SIZE_D);
		run_write();
		@(posedge clk);
		prepare_read(addr, 8'd1, SIZE_D);
		run_read();
		@(posedge clk);
		prepare_read(addr, 8'd3, SIZE_D);
		run_read();

		// Write and read raised together, AW goes first
		@(posedge clk);
		prepare_write(32'h200, 8'd3, SIZE_W);
		prepare_read(32'h200, 8'd3, SIZE_W);
		fork
			run_write();
			run_read();
		join

		repeat (4) @(posedge clk);
		$display("Summary: %0d errors, %0d bursts, %0d cycles", errors, bursts, cycle_cnt);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
common/axi_pkg.sv
common/axi_if.sv
axi_bridge/axi_write_master.sv
axi_bridge/axi_read_master.sv
design/axi_mem.sv
design/mem_port_top.sv
verification/tb_mem_port.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_port
RTL_TOP   ?= mem_port_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported failure, see $(LOG)"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
